//--- rv64_exu.f
common/exu_pkg.sv
common/md_if.sv
verilog/alu.sv
muldiv/multiplier.sv
muldiv/divider.sv
verilog/exu.sv
bench/exu_tb.sv

//--- bench/exu_tb.sv
`timescale 1ns/10ps

module exu_tb import exu_pkg::*;;

    localparam int xlen = 64;
    localparam logic [63:0] min_neg = 64'h8000_0000_0000_0000;

    logic            clock;
    logic            reset;
    logic            in_valid;
    logic            in_ready;
    exu_op_e         in_op;
    logic            in_word;
    logic [xlen-1:0] in_src1;
    logic [xlen-1:0] in_src2;
    logic [4:0]      in_rd;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_result;
    logic [4:0]      out_rd;

    logic [31:0]     rng_state;
    logic [4:0]      next_rd;
    logic            timed_out;
    int              errors;
    int              checks;
    int              tests;
    logic [63:0]     expect_res_q[$]; // results in issue order.
    logic [4:0]      expect_rd_q[$];

    exu #(.xlen(xlen)) i_exu (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_rd      (in_rd),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_rd     (out_rd)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] sign_extend_word(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // corner values show up often, the rest is full random.
    function automatic logic [63:0] random_operand();
        logic [31:0] pick;
        logic [31:0] hi;
        logic [31:0] lo;
        pick = next_random() % 8;
        hi   = next_random();
        lo   = next_random();
        case (pick)
            0: return '0;
            1: return '1;
            2: return min_neg;
            3: return 64'hffff_ffff_8000_0000; // most negative word.
            4: return {60'h0, lo[3:0]};
            default: return {hi, lo};
        endcase
    endfunction

    // riscv semantics. word ops extend the low halves, compute, then sign extend.
    function automatic logic [63:0] reference_result(input exu_op_e op, input logic word,
                                                     input logic [63:0] a,
                                                     input logic [63:0] b);
        logic [63:0] x;
        logic [63:0] y;
        logic [5:0]  sh;
        logic [63:0] r;
        logic        zext;
        zext = op inside {OP_SRL, OP_SLTU, OP_DIVU, OP_REMU};
        x    = a;
        y    = b;
        if (word) begin
            x = zext ? {32'h0, a[31:0]} : sign_extend_word(a[31:0]);
            y = zext ? {32'h0, b[31:0]} : sign_extend_word(b[31:0]);
        end
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        r  = '0;
        case (op)
            OP_ADD:  r = x + y;
            OP_SUB:  r = x - y;
            OP_SLL:  r = x << sh;
            OP_SLT:  r = {63'h0, $signed(x) < $signed(y)};
            OP_SLTU: r = {63'h0, x < y};
            OP_XOR:  r = x ^ y;
            OP_SRL:  r = x >> sh;
            OP_SRA:  r = $signed(x) >>> sh;
            OP_OR:   r = x | y;
            OP_AND:  r = x & y;
            OP_MUL:  r = x * y;
            OP_DIV: begin
                if (y == '0) begin
                    r = '1;
                end else if (x == min_neg && y == '1) begin
                    r = x;
                end else begin
                    r = $signed(x) / $signed(y);
                end
            end
            OP_DIVU: begin
                if (y == '0) begin
                    r = '1;
                end else begin
                    r = x / y;
                end
            end
            OP_REM: begin
                if (y == '0) begin
                    r = x;
                end else if (x == min_neg && y == '1) begin
                    r = '0;
                end else begin
                    r = $signed(x) % $signed(y);
                end
            end
            OP_REMU: begin
                if (y == '0) begin
                    r = x;
                end else begin
                    r = x % y;
                end
            end
            default: r = '0;
        endcase
        return word ? sign_extend_word(r[31:0]) : r;
    endfunction

    task automatic check_output(input string name);
        logic [63:0] exp_res;
        logic [4:0]  exp_rd;
        checks++;
        assert (expect_res_q.size() > 0) else begin
            $display("%s: output transfer with no operation pending", name);
            errors++;
        end
        if (expect_res_q.size() > 0) begin
            exp_res = expect_res_q.pop_front();
            exp_rd  = expect_rd_q.pop_front();
            checks += 2;
            assert (out_result === exp_res) else begin
                $display("ERROR %s: result expected %h actual %h", name, exp_res, out_result);
                errors++;
            end
            assert (out_rd === exp_rd) else begin
                $display("ERROR %s: rd expected %0d actual %0d", name, exp_rd, out_rd);
                errors++;
            end
        end
    endtask

    task automatic idle_cycle(input string name);
        in_valid  = 1'b0;
        out_ready = (next_random() % 10) >= 3;
        #3;
        checks++;
        assert (out_valid === 1'b0) else begin
            $display("%s: out_valid high with no input offered", name);
            errors++;
        end
        @(negedge clock);
    endtask

    // offers one op and holds it until the input handshake.
    task automatic drive_op(input string name, input exu_op_e op, input logic word,
                            input logic [63:0] a, input logic [63:0] b);
        logic [63:0] held;
        logic        stalled;
        logic        taken;
        logic        single;
        int          waited;
        in_valid = 1'b1;
        in_op    = op;
        in_word  = word;
        in_src1  = a;
        in_src2  = b;
        in_rd    = next_rd;
        expect_rd_q.push_back(next_rd);
        expect_res_q.push_back(reference_result(op, word, a, b));
        next_rd  = next_rd + 1'b1;
        single   = !(op inside {OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU});
        stalled  = 1'b0;
        taken    = 1'b0;
        held     = '0;
        waited   = 0;
        while (!taken && waited < 200) begin
            out_ready = (next_random() % 10) >= 3; // low about 30 percent.
            #3; // one ns before the rising edge.
            if (stalled) begin
                checks++;
                assert (out_valid === 1'b1 && out_result === held) else begin
                    $display("ERROR %s: held result expected %h actual %h", name, held,
                             out_result);
                    errors++;
                end
            end
            if (single) begin
                checks++;
                assert (out_valid === 1'b1 && in_ready === out_ready) else begin
                    $display("%s: single-cycle op not passed straight through", name);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                check_output(name);
            end
            checks++;
            assert (!in_ready || (out_valid && out_ready)) else begin
                $display("%s: input consumed without an output transfer", name);
                errors++;
            end
            taken   = in_ready;
            stalled = out_valid && !out_ready;
            held    = out_result;
            @(negedge clock);
            waited++;
        end
        in_valid = 1'b0;
        if (!taken) begin
            $display("%s: timeout, no input handshake within 200 cycles", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // kind 0 alu, 1 multiply, 2 divide, otherwise a mixed stream with gaps.
    task automatic run_test(input string name, input int count, input int kind);
        int          start_errors;
        int          i;
        exu_op_e     op;
        logic        word;
        logic [63:0] a;
        logic [63:0] b;
        start_errors = errors;
        for (i = 0; i < count && !timed_out; i++) begin
            word = next_random() % 2;
            a    = random_operand();
            b    = random_operand();
            case (kind)
                0: op = exu_op_e'(next_random() % 10);
                1: op = OP_MUL;
                2: begin
                    op = exu_op_e'(17 + next_random() % 4);
                    if (i % 10 == 5) begin
                        a = word ? 64'h1234_5678_8000_0000 : min_neg; // signed overflow.
                        b = '1;
                    end
                end
                default: begin
                    if (next_random() % 3 == 0) begin
                        op = exu_op_e'(16 + next_random() % 5);
                    end else begin
                        op = exu_op_e'(next_random() % 10);
                    end
                    if (next_random() % 4 == 0) begin
                        idle_cycle(name);
                    end
                end
            endcase
            drive_op(name, op, word, a, b);
        end
        checks++;
        assert (expect_res_q.size() == 0) else begin
            $display("%s: %0d operations ended without output", name, expect_res_q.size());
            errors++;
        end
        tests++;
        $display("%-12s %0d ops, %0d errors", name, i, errors - start_errors);
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = OP_ADD;
        in_word   = 1'b0;
        in_src1   = '0;
        in_src2   = '0;
        in_rd     = '0;
        out_ready = 1'b0;
        rng_state = 32'h35a4_c939;
        next_rd   = '0;
        timed_out = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;

        repeat (10) begin
            @(negedge clock);
            checks++;
            assert (out_valid === 1'b0) else begin
                $display("reset: out_valid not low during reset");
                errors++;
            end
        end
        reset = 1'b0;
        #3;
        checks++;
        assert (out_valid === 1'b0) else begin
            $display("reset: out_valid not low in the cycle after reset");
            errors++;
        end
        @(negedge clock);
        tests++;
        $display("%-12s %0d errors", "reset", errors);

        run_test("alu", 300, 0);
        if (!timed_out) begin
            run_test("multiply", 100, 1);
        end
        if (!timed_out) begin
            run_test("divide", 150, 2);
        end
        if (!timed_out) begin
            run_test("backpressure", 300, 3);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog/exu.sv
`timescale 1ns/10ps

module exu import exu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  exu_op_e         in_op,
    input  logic            in_word,
    input  logic [xlen-1:0] in_src1,
    input  logic [xlen-1:0] in_src2,
    input  logic [4:0]      in_rd,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_result,
    output logic [4:0]      out_rd
);

    exu_state_e      state;
    exu_state_e      state_next;
    logic            is_mul;
    logic            is_div;
    logic            is_iter;
    logic            unit_ready;
    logic            launch;
    logic            unit_done;
    logic [xlen-1:0] unit_result;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] res_q;

    md_if #(.xlen(xlen)) mul_if ();
    md_if #(.xlen(xlen)) div_if ();

    alu #(.xlen(xlen)) i_alu (
        .op     (in_op),
        .word   (in_word),
        .src1   (in_src1),
        .src2   (in_src2),
        .result (alu_result)
    );

    multiplier #(.xlen(xlen)) i_multiplier (
        .clock (clock),
        .reset (reset),
        .md    (mul_if)
    );

    divider #(.xlen(xlen)) i_divider (
        .clock (clock),
        .reset (reset),
        .md    (div_if)
    );

    // unit dispatch.
    assign is_mul     = (in_op == OP_MUL);
    assign is_div     = in_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign is_iter    = is_mul || is_div;
    assign unit_ready = is_mul ? mul_if.ready : div_if.ready;
    assign launch     = in_valid && is_iter && unit_ready
                        && (state == ST_IDLE || state == ST_WAIT_UNIT);

    assign mul_if.start     = launch && is_mul;
    assign mul_if.word      = in_word;
    assign mul_if.is_signed = 1'b0; // low product bits are sign agnostic.
    assign mul_if.sel_rem   = 1'b0;
    assign mul_if.a         = in_src1;
    assign mul_if.b         = in_src2;

    assign div_if.start     = launch && is_div;
    assign div_if.word      = in_word;
    assign div_if.is_signed = (in_op == OP_DIV) || (in_op == OP_REM);
    assign div_if.sel_rem   = (in_op == OP_REM) || (in_op == OP_REMU);
    assign div_if.a         = in_src1;
    assign div_if.b         = in_src2;

    // only one unit runs at a time.
    assign unit_done   = mul_if.done || div_if.done;
    assign unit_result = mul_if.done ? mul_if.result : div_if.result;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (in_valid && is_iter) begin
                    state_next = unit_ready ? ST_BUSY : ST_WAIT_UNIT;
                end
            end
            ST_WAIT_UNIT: begin
                if (unit_ready) begin
                    state_next = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (unit_done) begin
                    state_next = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (out_ready) begin
                    state_next = ST_IDLE; // output transfer also consumes the input.
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == ST_BUSY && unit_done) begin
            res_q <= unit_result;
        end
    end

    assign out_valid  = (state == ST_IDLE && in_valid && !is_iter) || (state == ST_HOLD);
    assign in_ready   = out_ready && ((state == ST_IDLE && !is_iter) || state == ST_HOLD);
    assign out_result = (state == ST_HOLD) ? res_q : alu_result;
    assign out_rd     = in_rd;

    a_mul_start_ready: assert property (@(posedge clock) disable iff (reset)
        mul_if.start |-> mul_if.ready)
        else $error("exu: multiplier started while busy");

    a_div_start_ready: assert property (@(posedge clock) disable iff (reset)
        div_if.start |-> div_if.ready)
        else $error("exu: divider started while busy");

    a_busy_no_valid: assert property (@(posedge clock) disable iff (reset)
        state == ST_BUSY |-> !out_valid)
        else $error("exu: out_valid raised while a unit is running");

    // upstream holds its op until the transfer.
    a_op_stable: assert property (@(posedge clock) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_op)))
        else $error("exu: in_op changed before transfer");

endmodule

//--- muldiv/divider.sv
`timescale 1ns/10ps

module divider #(
    parameter int xlen = 64
) (
    input  logic   clock,
    input  logic   reset,
    md_if.div_unit md
);

    localparam int HALF  = xlen / 2;
    localparam int CNT_W = $clog2(xlen + 1);

    logic             accept;
    logic [xlen-1:0]  a_w;
    logic [xlen-1:0]  b_w;
    logic [xlen-1:0]  a_op;
    logic [xlen-1:0]  b_op;
    logic             a_neg;
    logic             b_neg;
    logic [xlen-1:0]  abs_a;
    logic [xlen-1:0]  abs_b;
    logic [xlen-1:0]  min_mag;
    logic             by_zero;
    logic             overflow;
    logic [xlen-1:0]  a_res;
    logic [xlen-1:0]  sp_res;
    logic [xlen:0]    rem_shift;
    logic [xlen:0]    rem_diff;
    logic [xlen-1:0]  q_signed;
    logic [xlen-1:0]  r_signed;
    logic [xlen-1:0]  sel;
    logic [xlen-1:0]  fix_res;

    logic             ready_q;
    logic             busy;
    logic             fixup;
    logic             done_q;
    logic [CNT_W-1:0] count;
    logic             special_q;
    logic             a_neg_q;
    logic             q_neg_q;
    logic             word_q;
    logic             sel_rem_q;
    logic [xlen-1:0]  rem;
    logic [xlen-1:0]  quo;
    logic [xlen-1:0]  divisor;
    logic [xlen-1:0]  res_q;

    assign accept = ready_q && md.start;

    // operand preparation. word mode extends the low halves.
    assign a_w  = {{HALF{md.a[HALF-1]}}, md.a[HALF-1:0]};
    assign b_w  = {{HALF{md.b[HALF-1]}}, md.b[HALF-1:0]};
    assign a_op = !md.word ? md.a : md.is_signed ? a_w : {{HALF{1'b0}}, md.a[HALF-1:0]};
    assign b_op = !md.word ? md.b : md.is_signed ? b_w : {{HALF{1'b0}}, md.b[HALF-1:0]};

    assign a_neg = md.is_signed && a_op[xlen-1];
    assign b_neg = md.is_signed && b_op[xlen-1];
    assign abs_a = a_neg ? -a_op : a_op;
    assign abs_b = b_neg ? -b_op : b_op;

    // magnitude of the most negative value.
    assign min_mag = md.word ? {{HALF{1'b0}}, 1'b1, {(HALF-1){1'b0}}}
                             : {1'b1, {(xlen-1){1'b0}}};

    assign by_zero  = (b_op == '0);
    assign overflow = a_neg && (abs_a == min_mag) && (b_op == '1);

    // riscv results for divide by zero and signed overflow.
    assign a_res  = md.word ? a_w : md.a;
    assign sp_res = md.sel_rem ? (by_zero ? a_res : '0) : (by_zero ? '1 : a_res);

    // one restoring step.
    assign rem_shift = {rem, quo[xlen-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor};

    // in word mode the top of quo has been shifted clear by now.
    assign q_signed = q_neg_q ? -quo : quo;
    assign r_signed = a_neg_q ? -rem : rem; // remainder follows the dividend.
    assign sel      = sel_rem_q ? r_signed : q_signed;
    assign fix_res  = word_q ? {{HALF{sel[HALF-1]}}, sel[HALF-1:0]} : sel;

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b1;
            busy    <= 1'b0;
            fixup   <= 1'b0;
            done_q  <= 1'b0;
            count   <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                ready_q <= 1'b0;
                if (by_zero || overflow) begin
                    fixup <= 1'b1; // corner cases skip the loop.
                end else begin
                    busy  <= 1'b1;
                    count <= md.word ? CNT_W'(HALF) : CNT_W'(xlen);
                end
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy  <= 1'b0;
                    fixup <= 1'b1;
                end
            end else if (fixup) begin
                fixup  <= 1'b0;
                done_q <= 1'b1;
            end else if (done_q) begin
                ready_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rem       <= '0;
            quo       <= md.word ? {abs_a[HALF-1:0], {HALF{1'b0}}} : abs_a;
            divisor   <= abs_b;
            a_neg_q   <= a_neg;
            q_neg_q   <= a_neg ^ b_neg;
            word_q    <= md.word;
            sel_rem_q <= md.sel_rem;
            special_q <= by_zero || overflow;
            res_q     <= sp_res;
        end else if (busy) begin
            if (!rem_diff[xlen]) begin
                rem <= rem_diff[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= rem_shift[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end else if (fixup && !special_q) begin
            res_q <= fix_res; // sign correction.
        end
    end

    assign md.ready  = ready_q;
    assign md.done   = done_q;
    assign md.result = res_q;

endmodule

//--- muldiv/multiplier.sv
`timescale 1ns/10ps

module multiplier #(
    parameter int xlen = 64
) (
    input  logic   clock,
    input  logic   reset,
    md_if.mul_unit md
);

    localparam int HALF  = xlen / 2;
    localparam int CNT_W = $clog2(xlen + 1);

    logic             accept;
    logic             ready_q;
    logic             busy;
    logic             done_q;
    logic [CNT_W-1:0] count;
    logic             word_q;
    logic [xlen-1:0]  acc;
    logic [xlen-1:0]  mcand;
    logic [xlen-1:0]  mplier;

    assign accept = ready_q && md.start;

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b1;
            busy    <= 1'b0;
            done_q  <= 1'b0;
            count   <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                ready_q <= 1'b0;
                busy    <= 1'b1;
                count   <= md.word ? CNT_W'(HALF) : CNT_W'(xlen);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (done_q) begin
                ready_q <= 1'b1; // idle again one cycle after done.
            end
        end
    end

    // one multiplier bit per step, only the low xlen bits are kept.
    always_ff @(posedge clock) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= md.a;
            mplier <= md.b;
            word_q <= md.word;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign md.ready  = ready_q;
    assign md.done   = done_q;
    assign md.result = word_q ? {{HALF{acc[HALF-1]}}, acc[HALF-1:0]} : acc;

    // the unit never offers a result while it claims to be idle.
    a_done_not_ready: assert property (@(posedge clock) disable iff (reset)
        md.done |-> !md.ready)
        else $error("multiplier: done while ready");

endmodule

//--- verilog/alu.sv
`timescale 1ns/10ps

module alu import exu_pkg::*; #(
    parameter int xlen = 64
) (
    input  exu_op_e         op,
    input  logic            word,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    localparam int HALF = xlen / 2;
    localparam int SH_W = $clog2(xlen);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] a_zext;
    logic [SH_W-1:0] shamt;
    logic [xlen-1:0] raw;

    // word ops see the low halves, sign extended.
    // unsigned compares keep their order under sign extension.
    assign a = word ? {{HALF{src1[HALF-1]}}, src1[HALF-1:0]} : src1;
    assign b = word ? {{HALF{src2[HALF-1]}}, src2[HALF-1:0]} : src2;

    assign a_zext = word ? {{HALF{1'b0}}, src1[HALF-1:0]} : src1; // zero fill for srl.

    // one shift bit fewer in word mode.
    assign shamt = word ? {1'b0, src2[SH_W-2:0]} : src2[SH_W-1:0];

    always_comb begin
        case (op)
            OP_ADD: begin
                raw = a + b;
            end
            OP_SUB: begin
                raw = a - b;
            end
            OP_SLL: begin
                raw = a << shamt;
            end
            OP_SLT: begin
                raw = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            OP_SLTU: begin
                raw = {{(xlen-1){1'b0}}, a < b};
            end
            OP_XOR: begin
                raw = a ^ b;
            end
            OP_SRL: begin
                raw = a_zext >> shamt;
            end
            OP_SRA: begin
                raw = $signed(a) >>> shamt; // sign fill from the extended operand.
            end
            OP_OR: begin
                raw = a | b;
            end
            OP_AND: begin
                raw = a & b;
            end
            default: begin
                raw = '0; // iterative ops take their result from the units.
            end
        endcase
    end

    // word results are the low half, sign extended.
    assign result = word ? {{HALF{raw[HALF-1]}}, raw[HALF-1:0]} : raw;

endmodule

//--- common/md_if.sv
`timescale 1ns/10ps

interface md_if #(
    parameter int xlen = 64
) ();

    logic            start;     // one-cycle request pulse.
    logic            word;
    logic            is_signed;
    logic            sel_rem;   // divider returns the remainder.
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic            ready;     // unit idle.
    logic            done;      // one-cycle result pulse.
    logic [xlen-1:0] result;

    modport ctrl (
        output start, word, is_signed, sel_rem, a, b,
        input  ready, done, result
    );

    modport mul_unit (
        input  start, word, a, b,
        output ready, done, result
    );

    modport div_unit (
        input  start, word, is_signed, sel_rem, a, b,
        output ready, done, result
    );

endinterface

//--- common/exu_pkg.sv
package exu_pkg;

    localparam int OP_WIDTH = 5; // opcode field width.

    // single-cycle codes sit in the low half of the code space,
    // iterative codes start at 16.
    typedef enum logic [OP_WIDTH-1:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_SLL  = 5'd2,
        OP_SLT  = 5'd3,
        OP_SLTU = 5'd4,
        OP_XOR  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_OR   = 5'd8,
        OP_AND  = 5'd9,
        OP_MUL  = 5'd16, // low xlen bits of the product.
        OP_DIV  = 5'd17,
        OP_DIVU = 5'd18,
        OP_REM  = 5'd19,
        OP_REMU = 5'd20
    } exu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0, // single-cycle ops pass straight through.
        ST_WAIT_UNIT = 2'd1, // iterative op waits for its unit.
        ST_BUSY      = 2'd2, // unit running, upstream held.
        ST_HOLD      = 2'd3  // result registered and offered downstream.
    } exu_state_e;

endpackage
